/* bench/fmd_properties.sv */
`default_nettype none

module fmd_properties (
	input logic              clk,
	input logic              arst_n,
	input logic              in_valid,
	input fmd_pkg::fmd_req_t req,
	input logic              pre_valid,
	input logic              out_valid,
	input logic              busy
);
	timeunit 1ns;
	timeprecision 1ps;

	import fmd_pkg::*;

	// Pre-norm, product and post-norm registers give three cycles
	mul_latency: assert property (@(posedge clk) disable iff (!arst_n)
		(in_valid && !busy && (req.op == OP_MUL)) |-> ##3 out_valid)
		else $error("multiply result missing three cycles after the request");

	// A dropped request never reaches the pre-norm register
	busy_not_accepted: assert property (@(posedge clk) disable iff (!arst_n)
		busy |=> !pre_valid)
		else $error("busy raised for a request that entered pre-norm");

	reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind fmd_top fmd_properties u_fmd_properties (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.req       (req),
	.pre_valid (pre_valid),
	.out_valid (out_valid),
	.busy      (busy)
);

`default_nettype wire

/* bench/fmd_tb.sv */
`default_nettype none

module fmd_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import fmd_pkg::*;

	localparam int QUOT_BITS    = 27;
	localparam int CLK_HALF     = 20;
	localparam int RESET_CYCLES = 16;
	localparam int SEED         = 32'h610f_8dda;
	// Upper bound on requests issued by all tests together
	localparam int NUM_OPS      = 260;
	localparam int WATCHDOG_NS  = (NUM_OPS * 40 + RESET_CYCLES) * 2 * CLK_HALF;

	typedef struct packed {
		int       due;
		fmd_rsp_t rsp;
	} pending_t;

	logic      clk;
	logic      arst_n;
	logic      in_valid;
	fmd_req_t  req;
	logic      out_valid;
	fmd_rsp_t  rsp;
	logic      busy;

	int        cyc = 0;
	int        errors = 0;
	int        checks = 0;
	int        tests = 0;
	// Drive cycle of the last accepted divide
	int        div_start = -1000;
	pending_t  pending[$];

	fmd_top #(
		.QUOT_BITS (QUOT_BITS)
	) u_fmd_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.rsp       (rsp),
		.busy      (busy)
	);

	always #(CLK_HALF) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_rsp(input fmd_rsp_t got, input fmd_rsp_t want);
		checks++;
		if (got.word !== want.word) begin
			errors++;
			$display("[FAIL] rsp.word got %h expected %h", got.word, want.word);
		end
		if (got.flags !== want.flags) begin
			errors++;
			$display("[FAIL] rsp.flags got %h expected %h", got.flags, want.flags);
		end
	endtask

	task automatic check_busy(input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[FAIL] busy got %h expected %h", got, want);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model, IEEE-754 single with flush to zero and RNE
	////////////////////////////////////////////////////////////////////////////

	function automatic fmd_rsp_t expected_rsp(input fmd_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		fmd_rsp_t    r;
		logic        s;
		logic        zero_a;
		logic        zero_b;
		logic        inf_a;
		logic        inf_b;
		logic        nan_a;
		logic        nan_b;
		logic [63:0] ma;
		logic [63:0] mb;
		logic [63:0] v;
		logic [63:0] keep;
		logic [63:0] rest;
		logic [63:0] half;
		logic        st;
		int          e;
		int          p;
		int          sh;
		r      = '0;
		s      = a[31] ^ b[31];
		// Exponent zero covers denormals too
		zero_a = (a[30:23] == 8'h00);
		zero_b = (b[30:23] == 8'h00);
		inf_a  = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
		inf_b  = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
		nan_a  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
		nan_b  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
		if (nan_a || nan_b) begin
			r.word = 32'h7fc0_0000;
			return r;
		end
		if ((op == OP_MUL && ((zero_a && inf_b) || (inf_a && zero_b))) ||
		    (op == OP_DIV && ((zero_a && zero_b) || (inf_a && inf_b)))) begin
			r.word          = 32'h7fc0_0000;
			r.flags.invalid = 1'b1;
			return r;
		end
		if (inf_a || (op == OP_MUL && inf_b)) begin
			r.word = {s, 8'hff, 23'd0};
			return r;
		end
		if (op == OP_DIV && zero_b) begin
			r.word              = {s, 8'hff, 23'd0};
			r.flags.div_by_zero = 1'b1;
			return r;
		end
		if (zero_a || zero_b || inf_b) begin
			r.word = {s, 31'd0};
			return r;
		end
		ma = {40'd0, 1'b1, a[22:0]};
		mb = {40'd0, 1'b1, b[22:0]};
		// e holds the unbiased weight of the LSB of v
		if (op == OP_MUL) begin
			v  = ma * mb;
			st = 1'b0;
			e  = int'(a[30:23]) + int'(b[30:23]) - 300;
		end else begin
			v  = (ma << 40) / mb;
			st = ((ma << 40) % mb) != 64'd0;
			e  = int'(a[30:23]) - int'(b[30:23]) - 40;
		end
		p = 0;
		for (int i = 0; i < 64; i++) begin
			if (v[i]) begin
				p = i;
			end
		end
		sh   = p - 23;
		keep = v >> sh;
		rest = v & ((64'd1 << sh) - 64'd1);
		half = 64'd1 << (sh - 1);
		if ((rest > half) || ((rest == half) && (st || keep[0]))) begin
			keep = keep + 64'd1;
		end
		e = e + p + 127;
		if (keep[24]) begin
			keep = keep >> 1;
			e    = e + 1;
		end
		r.flags.inexact = (rest != 64'd0) || st;
		if (e >= 255) begin
			r.word           = {s, 8'hff, 23'd0};
			r.flags.overflow = 1'b1;
			r.flags.inexact  = 1'b1;
		end else if (e <= 0) begin
			r.word            = {s, 31'd0};
			r.flags.underflow = 1'b1;
			r.flags.inexact   = 1'b1;
		end else begin
			r.word = {s, e[7:0], keep[22:0]};
		end
		return r;
	endfunction

	function automatic fmd_rsp_t exact_rsp(input logic [31:0] w);
		fmd_rsp_t r;
		r      = '0;
		r.word = w;
		return r;
	endfunction

	function automatic logic [31:0] random_normal(input int lo, input int hi);
		logic [31:0] w;
		w[31]    = 1'($urandom_range(1, 0));
		w[30:23] = 8'($urandom_range(hi, lo));
		w[22:0]  = 23'($urandom);
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and response tracking
	////////////////////////////////////////////////////////////////////////////

	// Called 2 ns after a rising edge, returns at the same phase one cycle on
	task automatic issue(input fmd_op_e op, input logic [31:0] a, input logic [31:0] b,
		input fmd_rsp_t want);
		int       n;
		logic     want_busy;
		pending_t ent;
		n         = cyc;
		want_busy = (n > div_start) && (n <= div_start + QUOT_BITS + 2);
		in_valid  = 1'b1;
		req.op    = op;
		req.a     = a;
		req.b     = b;
		if (!want_busy) begin
			ent.due = n + ((op == OP_DIV) ? QUOT_BITS + 3 : 3);
			ent.rsp = want;
			pending.push_back(ent);
			if (op == OP_DIV) begin
				div_start = n;
			end
		end
		@(posedge clk);
		check_busy(busy, want_busy);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (pending.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		$display("Test %s finished with %0d mismatches", name, errors - err_start);
	endtask

	// Every result must land on its due cycle, in order
	always @(posedge clk) begin
		if (arst_n) begin
			if (pending.size() != 0 && pending[0].due == cyc && !out_valid) begin
				errors++;
				$display("Expected out_valid at cycle %0d but it stayed low", cyc);
				void'(pending.pop_front());
			end else if (out_valid) begin
				if (pending.size() == 0 || pending[0].due != cyc) begin
					errors++;
					$display("out_valid at cycle %0d with no result due", cyc);
				end else begin
					check_rsp(rsp, pending[0].rsp);
					void'(pending.pop_front());
				end
			end
		end
		cyc <= cyc + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_mul_exact();
		int e0;
		e0 = errors;
		issue(OP_MUL, 32'h4040_0000, 32'h40a0_0000, exact_rsp(32'h4170_0000));
		issue(OP_MUL, 32'h4000_0000, 32'h3f00_0000, exact_rsp(32'h3f80_0000));
		issue(OP_MUL, 32'h40e0_0000, 32'hc0c0_0000, exact_rsp(32'hc228_0000));
		issue(OP_MUL, 32'h4480_0000, 32'h3e80_0000, exact_rsp(32'h4380_0000));
		drain();
		end_test("mul_exact", e0);
	endtask

	// Back-to-back requests fill the multiply pipeline
	task automatic test_mul_random();
		int          e0;
		logic [31:0] a;
		logic [31:0] b;
		e0 = errors;
		for (int i = 0; i < 200; i++) begin
			a = random_normal(70, 180);
			b = random_normal(70, 180);
			issue(OP_MUL, a, b, expected_rsp(OP_MUL, a, b));
		end
		drain();
		end_test("mul_random", e0);
	endtask

	task automatic test_div();
		int          e0;
		logic [31:0] a;
		logic [31:0] b;
		e0 = errors;
		issue(OP_DIV, 32'h40c0_0000, 32'h4040_0000, exact_rsp(32'h4000_0000));
		drain();
		issue(OP_DIV, 32'h3f80_0000, 32'h4080_0000, exact_rsp(32'h3e80_0000));
		drain();
		issue(OP_DIV, 32'h3f80_0000, 32'h4040_0000,
			expected_rsp(OP_DIV, 32'h3f80_0000, 32'h4040_0000));
		drain();
		for (int i = 0; i < 20; i++) begin
			a = random_normal(70, 180);
			b = random_normal(70, 180);
			issue(OP_DIV, a, b, expected_rsp(OP_DIV, a, b));
			drain();
		end
		end_test("div", e0);
	endtask

	task automatic special_case(input fmd_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		issue(op, a, b, expected_rsp(op, a, b));
		drain();
	endtask

	task automatic test_special();
		int e0;
		e0 = errors;
		// Zero and denormal operands
		special_case(OP_MUL, 32'h0000_0000, 32'h4040_0000);
		special_case(OP_MUL, 32'h0000_1234, 32'hc000_0000);
		special_case(OP_DIV, 32'h0000_0000, 32'h40a0_0000);
		// Invalid operations
		special_case(OP_MUL, 32'h7f80_0000, 32'h0000_0000);
		special_case(OP_MUL, 32'h0000_0000, 32'hff80_0000);
		special_case(OP_DIV, 32'h0000_0000, 32'h0000_0000);
		special_case(OP_DIV, 32'h7f80_0000, 32'hff80_0000);
		// Division by zero, a denormal divisor counts as zero
		special_case(OP_DIV, 32'hc040_0000, 32'h0000_0000);
		special_case(OP_DIV, 32'h4000_0000, 32'h0000_0001);
		// NaN in, quiet NaN out
		special_case(OP_MUL, 32'h7f80_0001, 32'h4000_0000);
		special_case(OP_DIV, 32'h3f80_0000, 32'hffc0_0000);
		special_case(OP_MUL, 32'h7f80_0000, 32'h4040_0000);
		special_case(OP_DIV, 32'h4040_0000, 32'h7f80_0000);
		// Range limits
		special_case(OP_MUL, 32'h7f00_0000, 32'h4080_0000);
		special_case(OP_MUL, 32'h7f7f_ffff, 32'h4000_0000);
		special_case(OP_DIV, 32'h7f00_0000, 32'h3e80_0000);
		special_case(OP_MUL, 32'h0d80_0000, 32'h0d80_0000);
		special_case(OP_DIV, 32'h0d80_0000, 32'h7300_0000);
		end_test("special", e0);
	endtask

	task automatic test_busy();
		int e0;
		e0 = errors;
		issue(OP_DIV, 32'h3f80_0000, 32'h4040_0000,
			expected_rsp(OP_DIV, 32'h3f80_0000, 32'h4040_0000));
		repeat (4) @(posedge clk);
		#2;
		// Both land inside the divide window and must be dropped
		issue(OP_MUL, 32'h4040_0000, 32'h40a0_0000, exact_rsp(32'h4170_0000));
		issue(OP_DIV, 32'h40c0_0000, 32'h4040_0000, exact_rsp(32'h4000_0000));
		drain();
		issue(OP_MUL, 32'h4040_0000, 32'h40a0_0000, exact_rsp(32'h4170_0000));
		drain();
		end_test("busy", e0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk      = 1'b0;
		arst_n   = 1'b0;
		in_valid = 1'b0;
		req      = '0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		arst_n = 1'b1;
		test_mul_exact();
		test_mul_random();
		test_div();
		test_special();
		test_busy();
		$display("Summary: %0d tests, %0d checks, %0d failures", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests completed");
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/fmd_frac_div.sv */
`default_nettype none

module fmd_frac_div #(
	parameter int QUOT_BITS = 27
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               pre_valid,
	input  fmd_pkg::fmd_pre_t  pre,
	output logic               div_valid,
	output fmd_pkg::fmd_frac_t div,
	output logic               div_busy
);
	import fmd_pkg::*;

	localparam int CNT_W = $clog2(QUOT_BITS);

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_e;

	div_state_e           state;
	logic [CNT_W-1:0]     cnt;
	logic                 start;
	// Partial remainder stays below twice the divisor
	logic [FRAC_W:0]      rem;
	logic [FRAC_W-1:0]    divisor;
	logic [QUOT_BITS-1:0] quot;
	logic [FRAC_W+1:0]    diff;
	logic                 q_bit;
	logic [FRAC_W:0]      rem_keep;
	fmd_pre_t             op_q;

	assign start = pre_valid && (pre.op == OP_DIV) && (state == DIV_IDLE);

	////////////////////////////////////////////////////////////////////////////
	// Restoring step
	////////////////////////////////////////////////////////////////////////////

	assign diff     = {1'b0, rem} - {2'b00, divisor};
	// No borrow means the divisor fits
	assign q_bit    = !diff[FRAC_W+1];
	assign rem_keep = q_bit ? diff[FRAC_W:0] : rem;

	////////////////////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= DIV_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				DIV_IDLE: begin
					if (start) begin
						state <= DIV_RUN;
						cnt   <= '0;
					end
				end
				DIV_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(QUOT_BITS - 1)) begin
						state <= DIV_DONE;
					end
				end
				DIV_DONE: begin
					state <= DIV_IDLE;
				end
				default: begin
					state <= DIV_IDLE;
				end
			endcase
		end
	end

	// First bit out is the integer bit of a/b, which lies in (0.5, 2)
	always_ff @(posedge clk) begin
		if (start) begin
			rem     <= {1'b0, pre.frac_a};
			divisor <= pre.frac_b;
			op_q    <= pre;
		end else if (state == DIV_RUN) begin
			rem  <= {rem_keep[FRAC_W-1:0], 1'b0};
			quot <= {quot[QUOT_BITS-2:0], q_bit};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Result
	////////////////////////////////////////////////////////////////////////////

	assign div_valid  = (state == DIV_DONE);
	assign div_busy   = (state != DIV_IDLE);
	// Integer bit lands on the MSB of the significand
	assign div.sig    = SIG_W'(quot) << (SIG_W - QUOT_BITS);
	assign div.sticky = |rem;
	assign div.pre    = op_q;

endmodule

`default_nettype wire

/* hw/fmd_frac_mul.sv */
`default_nettype none

module fmd_frac_mul (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               pre_valid,
	input  fmd_pkg::fmd_pre_t  pre,
	output logic               mul_valid,
	output fmd_pkg::fmd_frac_t mul
);
	import fmd_pkg::*;

	logic take;

	// Divides go to the iterative path
	assign take = pre_valid && (pre.op == OP_MUL);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mul_valid <= 1'b0;
		end else begin
			mul_valid <= take;
		end
	end

	// Full product, binary point between bits 46 and 45
	always_ff @(posedge clk) begin
		if (take) begin
			mul.sig    <= pre.frac_a * pre.frac_b;
			// Nothing is lost, every product bit is kept
			mul.sticky <= 1'b0;
			mul.pre    <= pre;
		end
	end

endmodule

`default_nettype wire

/* hw/fmd_pkg.sv */
`default_nettype none

package fmd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Single-precision field widths
	////////////////////////////////////////////////////////////////////////////

	// Mantissa including the hidden bit
	localparam int FRAC_W = 24;
	localparam int MAN_W  = FRAC_W - 1;
	localparam int EXP_W  = 8;
	localparam int BIAS   = 127;
	// Largest biased exponent, reserved for inf and NaN
	localparam int EXP_MAX = 255;
	// Signed working exponent, wide enough for sum and difference
	localparam int WEXP_W = 10;
	// Raw significand out of the fractional datapath
	localparam int SIG_W  = 2 * FRAC_W;

	// Canonical quiet NaN
	localparam logic [31:0] QNAN = 32'h7fc0_0000;

	typedef enum logic {
		OP_MUL,
		OP_DIV
	} fmd_op_e;

	// Denormals classify as zero
	typedef enum logic [1:0] {
		CLS_ZERO,
		CLS_NORM,
		CLS_INF,
		CLS_NAN
	} fmd_class_e;

	////////////////////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		fmd_op_e     op;
		logic [31:0] a;
		logic [31:0] b;
	} fmd_req_t;

	typedef struct packed {
		fmd_op_e                  op;
		logic                     sign;
		logic signed [WEXP_W-1:0] exp;
		logic [FRAC_W-1:0]        frac_a;
		logic [FRAC_W-1:0]        frac_b;
		fmd_class_e               cls_a;
		fmd_class_e               cls_b;
		logic                     exp_ovf;
		logic                     exp_unf;
	} fmd_pre_t;

	typedef struct packed {
		logic [SIG_W-1:0] sig;
		logic             sticky;
		fmd_pre_t         pre;
	} fmd_frac_t;

	typedef struct packed {
		logic invalid;
		logic div_by_zero;
		logic overflow;
		logic underflow;
		logic inexact;
	} fmd_flags_t;

	typedef struct packed {
		logic [31:0] word;
		fmd_flags_t  flags;
	} fmd_rsp_t;

endpackage

`default_nettype wire

/* hw/fmd_post_norm.sv */
`default_nettype none

module fmd_post_norm (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               frac_valid,
	input  fmd_pkg::fmd_frac_t frac,
	output logic               out_valid,
	output fmd_pkg::fmd_rsp_t  rsp
);
	import fmd_pkg::*;

	fmd_pre_t                 p;
	logic                     is_div;
	logic                     hi;
	logic [FRAC_W-1:0]        mant;
	logic                     guard;
	logic                     rnd;
	logic                     sticky;
	logic                     round_up;
	logic [FRAC_W:0]          mant_rnd;
	logic signed [WEXP_W-1:0] exp_in;
	logic signed [WEXP_W-1:0] exp_fin;
	logic                     ovf;
	logic                     unf;
	logic                     a_zero;
	logic                     b_zero;
	logic                     a_inf;
	logic                     b_inf;
	logic                     any_nan;
	logic                     invalid_op;
	logic                     res_inf;
	logic                     res_zero;
	logic                     dbz;
	fmd_rsp_t                 rsp_d;

	assign p      = frac.pre;
	assign is_div = (p.op == OP_DIV);
	assign hi     = frac.sig[SIG_W-1];

	////////////////////////////////////////////////////////////////////////////
	// Normalize and round
	////////////////////////////////////////////////////////////////////////////

	// Leading one is either the MSB or the bit below it
	always_comb begin
		if (hi) begin
			mant   = frac.sig[SIG_W-1 -: FRAC_W];
			guard  = frac.sig[SIG_W-1-FRAC_W];
			rnd    = frac.sig[SIG_W-2-FRAC_W];
			sticky = (|frac.sig[SIG_W-3-FRAC_W:0]) | frac.sticky;
		end else begin
			mant   = frac.sig[SIG_W-2 -: FRAC_W];
			guard  = frac.sig[SIG_W-2-FRAC_W];
			rnd    = frac.sig[SIG_W-3-FRAC_W];
			sticky = (|frac.sig[SIG_W-4-FRAC_W:0]) | frac.sticky;
		end
	end

	// Ties go to the even mantissa
	assign round_up = guard & (rnd | sticky | mant[0]);
	assign mant_rnd = {1'b0, mant} + round_up;

	// Divide significand sits one place higher than the product's
	assign exp_in  = p.exp;
	assign exp_fin = exp_in + WEXP_W'(hi) + WEXP_W'(mant_rnd[FRAC_W]) - WEXP_W'(is_div);
	assign ovf     = p.exp_ovf | (exp_fin >= EXP_MAX);
	assign unf     = p.exp_unf | (exp_fin <= 0);

	////////////////////////////////////////////////////////////////////////////
	// Special cases
	////////////////////////////////////////////////////////////////////////////

	assign a_zero  = (p.cls_a == CLS_ZERO);
	assign b_zero  = (p.cls_b == CLS_ZERO);
	assign a_inf   = (p.cls_a == CLS_INF);
	assign b_inf   = (p.cls_b == CLS_INF);
	assign any_nan = (p.cls_a == CLS_NAN) | (p.cls_b == CLS_NAN);

	// 0*inf, 0/0, inf/inf
	assign invalid_op = is_div ? ((a_zero & b_zero) | (a_inf & b_inf))
	                           : ((a_zero & b_inf) | (a_inf & b_zero));
	assign res_inf    = is_div ? (a_inf | b_zero) : (a_inf | b_inf);
	assign res_zero   = is_div ? (a_zero | b_inf) : (a_zero | b_zero);
	assign dbz        = is_div & b_zero & !a_inf;

	always_comb begin
		rsp_d = '0;
		if (any_nan | invalid_op) begin
			rsp_d.word          = QNAN;
			rsp_d.flags.invalid = invalid_op;
		end else if (res_inf) begin
			rsp_d.word              = {p.sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
			rsp_d.flags.div_by_zero = dbz;
		end else if (res_zero) begin
			rsp_d.word = {p.sign, {(EXP_W + MAN_W){1'b0}}};
		end else if (ovf) begin
			rsp_d.word           = {p.sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
			rsp_d.flags.overflow = 1'b1;
			rsp_d.flags.inexact  = 1'b1;
		end else if (unf) begin
			// Denormal results flush to signed zero
			rsp_d.word            = {p.sign, {(EXP_W + MAN_W){1'b0}}};
			rsp_d.flags.underflow = 1'b1;
			rsp_d.flags.inexact   = 1'b1;
		end else begin
			rsp_d.word          = {p.sign, exp_fin[EXP_W-1:0], mant_rnd[MAN_W-1:0]};
			rsp_d.flags.inexact = guard | rnd | sticky;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= frac_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (frac_valid) begin
			rsp <= rsp_d;
		end
	end

endmodule

`default_nettype wire

/* hw/fmd_pre_norm.sv */
`default_nettype none

module fmd_pre_norm (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  fmd_pkg::fmd_req_t req,
	output logic              pre_valid,
	output fmd_pkg::fmd_pre_t pre
);
	import fmd_pkg::*;

	logic                     sign_a;
	logic                     sign_b;
	logic [EXP_W-1:0]         exp_a;
	logic [EXP_W-1:0]         exp_b;
	logic [MAN_W-1:0]         man_a;
	logic [MAN_W-1:0]         man_b;
	fmd_class_e               cls_a;
	fmd_class_e               cls_b;
	logic                     op_div;
	logic                     both_norm;
	logic [WEXP_W-1:0]        exp_sum;
	logic [WEXP_W-1:0]        exp_dif;
	logic signed [WEXP_W-1:0] exp_work;
	fmd_pre_t                 pre_d;

	// Zero covers true zero and flushed denormals
	function automatic fmd_class_e classify(
		input logic [EXP_W-1:0] e,
		input logic [MAN_W-1:0] m
	);
		fmd_class_e c;
		if (e == '0) begin
			c = CLS_ZERO;
		end else if (e == '1) begin
			c = (m == '0) ? CLS_INF : CLS_NAN;
		end else begin
			c = CLS_NORM;
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Operand split
	////////////////////////////////////////////////////////////////////////////

	assign sign_a = req.a[31];
	assign sign_b = req.b[31];
	assign exp_a  = req.a[30:23];
	assign exp_b  = req.b[30:23];
	assign man_a  = req.a[MAN_W-1:0];
	assign man_b  = req.b[MAN_W-1:0];

	assign cls_a     = classify(exp_a, man_a);
	assign cls_b     = classify(exp_b, man_b);
	assign op_div    = (req.op == OP_DIV);
	assign both_norm = (cls_a == CLS_NORM) && (cls_b == CLS_NORM);

	////////////////////////////////////////////////////////////////////////////
	// Working exponent
	////////////////////////////////////////////////////////////////////////////

	// Multiply drops one bias, divide puts one back
	assign exp_sum = {2'b00, exp_a} + {2'b00, exp_b} - WEXP_W'(BIAS);
	assign exp_dif = {2'b00, exp_a} - {2'b00, exp_b} + WEXP_W'(BIAS);
	assign exp_work = op_div ? exp_dif : exp_sum;

	always_comb begin
		pre_d.op     = req.op;
		pre_d.sign   = sign_a ^ sign_b;
		pre_d.exp    = exp_work;
		// Hidden bit only for nonzero exponents, denormals flush to zero
		pre_d.frac_a = (exp_a == '0) ? '0 : {1'b1, man_a};
		pre_d.frac_b = (exp_b == '0) ? '0 : {1'b1, man_b};
		pre_d.cls_a  = cls_a;
		pre_d.cls_b  = cls_b;
		// Normalization and rounding move the exponent by -1..+2 at most,
		// so outside these bounds the result is already decided
		pre_d.exp_ovf = both_norm && (exp_work > EXP_MAX);
		pre_d.exp_unf = both_norm && (exp_work < -1);
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pre_valid <= 1'b0;
		end else begin
			pre_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			pre <= pre_d;
		end
	end

endmodule

`default_nettype wire

/* hw/fmd_top.sv */
`default_nettype none

module fmd_top #(
	parameter int QUOT_BITS = 27
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  fmd_pkg::fmd_req_t req,
	output logic              out_valid,
	output fmd_pkg::fmd_rsp_t rsp,
	output logic              busy
);
	import fmd_pkg::*;

	logic      pre_valid;
	fmd_pre_t  pre;
	logic      mul_valid;
	fmd_frac_t mul;
	logic      div_valid;
	fmd_frac_t div;
	logic      div_busy;
	logic      div_hold;
	logic      accept;
	logic      frac_valid;
	fmd_frac_t frac;

	// A divide in pre-norm already owns the divider
	assign div_hold = div_busy | (pre_valid & (pre.op == OP_DIV));
	assign accept   = in_valid & !div_hold;
	assign busy     = in_valid & div_hold;

	// Never both valid, nothing is accepted while a divide runs
	assign frac_valid = mul_valid | div_valid;
	assign frac       = div_valid ? div : mul;

	fmd_pre_norm u_pre_norm (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (accept),
		.req       (req),
		.pre_valid (pre_valid),
		.pre       (pre)
	);

	fmd_frac_mul u_frac_mul (
		.clk       (clk),
		.arst_n    (arst_n),
		.pre_valid (pre_valid),
		.pre       (pre),
		.mul_valid (mul_valid),
		.mul       (mul)
	);

	fmd_frac_div #(
		.QUOT_BITS (QUOT_BITS)
	) u_frac_div (
		.clk       (clk),
		.arst_n    (arst_n),
		.pre_valid (pre_valid),
		.pre       (pre),
		.div_valid (div_valid),
		.div       (div),
		.div_busy  (div_busy)
	);

	fmd_post_norm u_post_norm (
		.clk        (clk),
		.arst_n     (arst_n),
		.frac_valid (frac_valid),
		.frac       (frac),
		.out_valid  (out_valid),
		.rsp        (rsp)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the FP multiply/divide testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module fmd_tb -f sources.f -o fmd_sim

out=$(./obj_dir/fmd_sim 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "No errors"

/* sources.f */
hw/fmd_pkg.sv
hw/fmd_pre_norm.sv
hw/fmd_frac_mul.sv
hw/fmd_frac_div.sv
hw/fmd_post_norm.sv
hw/fmd_top.sv
bench/fmd_properties.sv
bench/fmd_tb.sv
